/* spiPkg.sv */
/*
 * Shared constants and types for the SPI byte master.
 * SPI mode, frame width and SCLK divider are fixed here per product.
 * Design and testbench files refer to these by scoped name.
 */
package spiPkg;

    // Frame and mode
    localparam int SPI_WIDTH     = 8;        // Bits per frame
    localparam int SPI_CNT_BITS  = 3;        // Bit counter width
    localparam logic SPI_CPOL    = 1'b0;     // SCLK idle level
    localparam logic SPI_CPHA    = 1'b0;     // 0 -> sample on leading edge

    // SCLK divider, clk cycles per half period
    localparam int SCLK_HALF_DIV = 4;
    localparam int SCLK_DIV_BITS = (SCLK_HALF_DIV > 1) ? $clog2(SCLK_HALF_DIV) : 1;
    localparam logic [SCLK_DIV_BITS-1:0] DIV_LOAD = SCLK_DIV_BITS'(SCLK_HALF_DIV - 1);

    // Controller counter compare points
    localparam logic [SPI_CNT_BITS-1:0] BIT_LAST   = SPI_CNT_BITS'(SPI_WIDTH - 1);
    localparam logic [SPI_CNT_BITS-1:0] STOP_PULSE = SPI_CNT_BITS'(SCLK_HALF_DIV - 1);
    localparam logic [SPI_CNT_BITS-1:0] STOP_END   = SPI_CNT_BITS'(SCLK_HALF_DIV);

    typedef logic [SPI_WIDTH-1:0] spiByte_t;

    // Edge strobes from the clock generator
    typedef struct packed {
        logic lead;     // First edge of a bit, one cycle
        logic trail;    // Second edge of a bit, one cycle
        logic level;    // Current SCLK value
    } sclkEdge_t;

    // Outward pin group
    typedef struct packed {
        logic sclk;
        logic mosi;
        logic csn;      // Active low chip select
    } spiPins_t;

    // Frame states
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        XFER = 2'd1,
        STOP = 2'd2
    } spiState_e;

endpackage

/* spiClockGen.sv */
/*
 * Serial clock generator working inside the clk domain.
 * Divides clk into SCLK half periods while i_run is high and emits
 * one-cycle lead and trail strobes along with the SCLK level.
 */
module spiClockGen (
    input  logic               clk,
    input  logic               reset,
    input  logic               i_run,
    output spiPkg::sclkEdge_t  o_edge
);

    logic [spiPkg::SCLK_DIV_BITS-1:0] divCnt;   // Cycles left in half period
    logic phase;                                // 0 -> next edge is lead
    logic leadQ;
    logic trailQ;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            divCnt <= spiPkg::DIV_LOAD;
            phase  <= 1'b0;
            leadQ  <= 1'b0;
            trailQ <= 1'b0;
        end else if (!i_run) begin
            // Parked, restart divider on next run
            divCnt <= spiPkg::DIV_LOAD;
            phase  <= 1'b0;
            leadQ  <= 1'b0;
            trailQ <= 1'b0;
        end else if (divCnt == '0) begin
            // Half period done, emit one edge
            divCnt <= spiPkg::DIV_LOAD;
            phase  <= ~phase;
            leadQ  <= ~phase;
            trailQ <= phase;
        end else begin
            divCnt <= divCnt - 1'b1;
            leadQ  <= 1'b0;
            trailQ <= 1'b0;
        end
    end

    // Level follows phase, idle value from CPOL
    assign o_edge = '{
        lead:  leadQ,
        trail: trailQ,
        level: phase ^ spiPkg::SPI_CPOL
    };

endmodule

/* spiShifter.sv */
/*
 * Combined transmit and receive shift register for one SPI frame.
 * Loads a byte on i_load, drives MOSI MSB first and shifts MISO in
 * at the bottom, so the register ends the frame holding the reply.
 */
module spiShifter (
    input  logic               clk,
    input  logic               reset,
    input  logic               i_load,
    input  spiPkg::spiByte_t   i_txByte,
    input  spiPkg::sclkEdge_t  i_edge,
    input  logic               i_miso,
    output logic               o_mosi,
    output spiPkg::spiByte_t   o_rxByte
);

    spiPkg::spiByte_t shiftReg;    // Tx bits out the top, Rx bits in the bottom
    logic sampleNow;
    logic shiftNow;

    // Mode 0 samples on lead and changes data on trail
    // CPHA 1 swaps the two edges
    assign sampleNow = (spiPkg::SPI_CPHA == 1'b0) ? i_edge.lead  : i_edge.trail;
    assign shiftNow  = (spiPkg::SPI_CPHA == 1'b0) ? i_edge.trail : i_edge.lead;

    // Data path register
    always_ff @(posedge clk) begin
        if (i_load) begin
            shiftReg <= i_txByte;
        end else if (sampleNow) begin
            shiftReg <= {shiftReg[spiPkg::SPI_WIDTH-2:0], i_miso};  // MISO in at LSB
        end
    end

    // MOSI pin register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            o_mosi <= 1'b0;
        end else if (i_load) begin
            o_mosi <= i_txByte[spiPkg::SPI_WIDTH-1];    // MSB out right away
        end else if (shiftNow) begin
            // Top bit is the next one once the sample has shifted
            o_mosi <= shiftReg[spiPkg::SPI_WIDTH-1];
        end
    end

    assign o_rxByte = shiftReg;    // Full reply after the last sample

endmodule

/* spiController.sv */
/*
 * Frame FSM of the SPI master: IDLE, XFER and STOP.
 * Accepts host bytes, runs the serial clock, counts trail edges and
 * returns the received byte with a one-cycle o_rxValid pulse.
 * A byte offered during STOP keeps chip select low for the next frame.
 */
module spiController (
    input  logic               clk,
    input  logic               reset,
    input  logic               i_txValid,
    input  spiPkg::sclkEdge_t  i_edge,
    input  spiPkg::spiByte_t   i_rxWord,
    output logic               o_load,
    output logic               o_run,
    output logic               o_csn,
    output logic               o_txReady,
    output logic               o_rxValid,
    output spiPkg::spiByte_t   o_rxByte
);

    spiPkg::spiState_e state;
    logic [spiPkg::SPI_CNT_BITS-1:0] bitCnt;   // Trails in XFER, cycles in STOP
    logic pending;                             // Next byte already taken in STOP
    logic accept;
    logic lastTrail;

    // Ready in IDLE and in STOP until a next byte is taken
    assign o_txReady = (state == spiPkg::IDLE) || ((state == spiPkg::STOP) && !pending);
    assign accept    = i_txValid && o_txReady;
    assign o_load    = accept;     // Shifter takes i_txByte on the same edge

    assign lastTrail = (state == spiPkg::XFER) && i_edge.trail
                       && (bitCnt == spiPkg::BIT_LAST);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= spiPkg::IDLE;
            bitCnt    <= '0;
            pending   <= 1'b0;
            o_run     <= 1'b0;
            o_csn     <= 1'b1;
            o_rxValid <= 1'b0;
        end else begin
            o_rxValid <= 1'b0;     // Pulse by default low
            unique case (state)
                spiPkg::IDLE: begin
                    if (accept) begin
                        state  <= spiPkg::XFER;
                        bitCnt <= '0;
                        o_run  <= 1'b1;
                        o_csn  <= 1'b0;    // Select on the accepting edge
                    end
                end
                spiPkg::XFER: begin
                    if (lastTrail) begin
                        // Final bit done, park SCLK
                        state  <= spiPkg::STOP;
                        bitCnt <= '0;
                        o_run  <= 1'b0;
                    end else if (i_edge.trail) begin
                        bitCnt <= bitCnt + 1'b1;
                    end
                end
                spiPkg::STOP: begin
                    if (bitCnt == spiPkg::STOP_PULSE) begin
                        o_rxValid <= 1'b1;     // One half period after last trail
                    end
                    if (bitCnt == spiPkg::STOP_END) begin
                        bitCnt  <= '0;
                        pending <= 1'b0;
                        if (pending || accept) begin
                            state <= spiPkg::XFER;     // Back to back, csn stays low
                            o_run <= 1'b1;
                        end else begin
                            state <= spiPkg::IDLE;
                            o_csn <= 1'b1;
                        end
                    end else begin
                        bitCnt <= bitCnt + 1'b1;
                        if (accept) begin
                            pending <= 1'b1;   // Byte already in shifter
                        end
                    end
                end
                default: begin
                    state <= spiPkg::IDLE;
                end
            endcase
        end
    end

    // Received byte, held until the next frame ends
    always_ff @(posedge clk) begin
        if (lastTrail) begin
            o_rxByte <= i_rxWord;
        end
    end

endmodule

/* spiTop.sv */
/*
 * Top level of the SPI byte master.
 * Connects clock generator, frame controller and shift register
 * between the host strobes and the SPI pin group.
 */
module spiTop (
    input  logic              clk,
    input  logic              reset,
    input  spiPkg::spiByte_t  i_txByte,
    input  logic              i_txValid,
    output logic              o_txReady,
    output spiPkg::spiByte_t  o_rxByte,
    output logic              o_rxValid,
    input  logic              i_miso,
    output spiPkg::spiPins_t  o_spi
);

    spiPkg::sclkEdge_t sclkEdge;     // Strobes and SCLK level
    spiPkg::spiByte_t  shiftWord;    // Shifter contents toward controller
    logic load;
    logic run;
    logic csn;
    logic mosi;

    spiClockGen clkGen0 (
        .clk    (clk),
        .reset  (reset),
        .i_run  (run),
        .o_edge (sclkEdge)
    );

    spiController ctrl0 (
        .clk       (clk),
        .reset     (reset),
        .i_txValid (i_txValid),
        .i_edge    (sclkEdge),
        .i_rxWord  (shiftWord),
        .o_load    (load),
        .o_run     (run),
        .o_csn     (csn),
        .o_txReady (o_txReady),
        .o_rxValid (o_rxValid),
        .o_rxByte  (o_rxByte)
    );

    spiShifter shift0 (
        .clk      (clk),
        .reset    (reset),
        .i_load   (load),
        .i_txByte (i_txByte),
        .i_edge   (sclkEdge),
        .i_miso   (i_miso),
        .o_mosi   (mosi),
        .o_rxByte (shiftWord)
    );

    // Pin group out
    assign o_spi = '{sclk: sclkEdge.level, mosi: mosi, csn: csn};

endmodule

/* spiTb_chk.sv */
/*
 * Concurrent assertions on the SPI pins and host strobes.
 * Bound into spiTop by the testbench, which reads failCount at the end of the run.
 */
module spiTb_chk (
    input logic               clk,
    input logic               reset,
    input spiPkg::spiPins_t   i_spi,
    input logic               i_rxValid,
    input logic               i_txReady,
    input spiPkg::spiState_e  i_state
);

    int failCount = 0;     // Failed assertion count

    // SCLK parked while deselected
    csnIdleSclk: assert property (@(posedge clk) disable iff (reset)
        i_spi.csn |-> (i_spi.sclk == spiPkg::SPI_CPOL))
        else begin
            $error("sclk away from idle level while csn is high");
            failCount++;
        end

    // Receive strobe is a single cycle
    rxPulse: assert property (@(posedge clk) disable iff (reset)
        i_rxValid |=> !i_rxValid)
        else begin
            $error("o_rxValid held for more than one cycle");
            failCount++;
        end

    // No new byte taken mid frame
    busyXfer: assert property (@(posedge clk) disable iff (reset)
        (i_state == spiPkg::XFER) |-> !i_txReady)
        else begin
            $error("o_txReady high during XFER");
            failCount++;
        end

    // Deselected whenever the FSM is idle
    idleCsn: assert property (@(posedge clk) disable iff (reset)
        (i_state == spiPkg::IDLE) |-> i_spi.csn)
        else begin
            $error("csn low in IDLE");
            failCount++;
        end

endmodule

/* spiTb.sv */
/*
 * Testbench for the SPI byte master.
 * Drives host bytes on the falling clk edge, models a mode 0 SPI slave
 * on the pins and compares every frame against the slave model queues.
 */
module spiTb;

    logic clk = 1'b0;
    logic reset = 1'b1;
    spiPkg::spiByte_t txByte = '0;
    logic txValid = 1'b0;
    logic txReady;
    spiPkg::spiByte_t rxByte;
    logic rxValid;
    logic miso = 1'b0;
    spiPkg::spiPins_t spi;

    // Slave model
    spiPkg::spiPins_t pinsQ;       // Pins at previous falling clk edge
    spiPkg::spiByte_t slvReply;    // Reply of the current frame
    spiPkg::spiByte_t slvOut;
    spiPkg::spiByte_t slvIn;
    int slvBits;
    int sclkRises;                 // Rising SCLK edges while selected
    int csnRises;
    spiPkg::spiByte_t mosiQ[$];    // Bytes the slave sampled
    spiPkg::spiByte_t replyQ[$];   // Bytes the slave sent back
    spiPkg::spiByte_t sentQ[$];    // Bytes the DUT accepted

    int errCount;
    int checksDone;
    int testCount;
    int passCount;
    int testErrStart;

    spiTop dut0 (
        .clk       (clk),
        .reset     (reset),
        .i_txByte  (txByte),
        .i_txValid (txValid),
        .o_txReady (txReady),
        .o_rxByte  (rxByte),
        .o_rxValid (rxValid),
        .i_miso    (miso),
        .o_spi     (spi)
    );

    bind spiTop spiTb_chk chk0 (
        .clk       (clk),
        .reset     (reset),
        .i_spi     (o_spi),
        .i_rxValid (o_rxValid),
        .i_txReady (o_txReady),
        .i_state   (ctrl0.state)
    );

    always #2 clk = ~clk;   // Period 4

    // Mode 0 slave, looks at the pins between clk edges
    always @(negedge clk) begin
        if (reset) begin
            pinsQ    = '{sclk: spiPkg::SPI_CPOL, mosi: 1'b0, csn: 1'b1};
            slvReply = spiPkg::spiByte_t'($urandom);
            slvOut   = '0;
            slvIn    = '0;
            slvBits  = 0;
            miso     = 1'b0;
        end else begin
            if (pinsQ.csn && !spi.csn) begin
                slvBits = 0;                // Selected, first bit out now
                slvOut  = slvReply;
                miso    = slvOut[spiPkg::SPI_WIDTH-1];
            end else if (!spi.csn) begin
                if (!pinsQ.sclk && spi.sclk) begin
                    slvIn = {slvIn[spiPkg::SPI_WIDTH-2:0], spi.mosi};   // Sample MOSI
                    slvBits++;
                    sclkRises++;
                    if (slvBits == spiPkg::SPI_WIDTH) begin
                        mosiQ.push_back(slvIn);
                        replyQ.push_back(slvReply);
                    end
                end else if (pinsQ.sclk && !spi.sclk) begin
                    if (slvBits == spiPkg::SPI_WIDTH) begin
                        // Frame done, next reply ready for a following frame
                        slvReply = spiPkg::spiByte_t'($urandom);
                        slvOut   = slvReply;
                        slvBits  = 0;
                    end else begin
                        slvOut = slvOut << 1;
                    end
                    miso = slvOut[spiPkg::SPI_WIDTH-1];
                end
            end
            if (!pinsQ.csn && spi.csn) begin
                csnRises++;
                miso = 1'b0;
            end
            pinsQ = spi;
        end
    end

    task automatic checkBit(input string name, input logic expected, input logic actual);
        checksDone++;
        assert (actual === expected) else begin
            $display("mismatch %s: expected %0b actual %0b", name, expected, actual);
            errCount++;
        end
    endtask

    task automatic checkByte(input string name, input spiPkg::spiByte_t expected,
                             input spiPkg::spiByte_t actual);
        checksDone++;
        assert (actual === expected) else begin
            $display("mismatch %s: expected %02h actual %02h", name, expected, actual);
            errCount++;
        end
    endtask

    task automatic checkInt(input string name, input int expected, input int actual);
        checksDone++;
        assert (actual == expected) else begin
            $display("mismatch %s: expected %0d actual %0d", name, expected, actual);
            errCount++;
        end
    endtask

    // Offer a byte at the current falling edge once o_txReady is high
    task automatic sendByte(input string name, input spiPkg::spiByte_t data);
        int n;
        n = 0;
        while (!txReady && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (!txReady) begin
            $display("%s: o_txReady never went high", name);
            errCount++;
        end else begin
            txByte  = data;
            txValid = 1'b1;
            sentQ.push_back(data);
            @(negedge clk);
            txValid = 1'b0;
        end
    endtask

    task automatic waitRxValid(input string name, output int cycles, output bit ok);
        cycles = 0;
        while (!rxValid && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        ok = rxValid;
        if (!ok) begin
            $display("%s: timed out waiting for o_rxValid", name);
            errCount++;
        end
    endtask

    task automatic waitCsnHigh(input string name);
        int n;
        n = 0;
        while (!spi.csn && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (!spi.csn) begin
            $display("%s: chip select stayed low", name);
            errCount++;
        end
    endtask

    // Compare one finished frame with the slave model
    task automatic checkFrame(input string name);
        spiPkg::spiByte_t sent;
        if (sentQ.size() == 0 || mosiQ.size() == 0 || replyQ.size() == 0) begin
            $display("%s: slave model has no finished frame to compare", name);
            errCount++;
        end else begin
            sent = sentQ.pop_front();
            checkByte({name, " mosi"}, sent, mosiQ.pop_front());
            checkByte({name, " rxByte"}, replyQ.pop_front(), rxByte);
        end
    endtask

    task automatic startTest();
        testErrStart = errCount;
        sentQ.delete();   // Leftovers of an earlier failure
        mosiQ.delete();
        replyQ.delete();
    endtask

    task automatic finishTest(input string name);
        testCount++;
        if (errCount == testErrStart) begin
            passCount++;
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed with %0d errors", name, errCount - testErrStart);
        end
    endtask

    initial begin
        spiPkg::spiByte_t b0;
        spiPkg::spiByte_t b1;
        int cycles;
        int base;
        int gap;
        bit ok;
        bit b2b;
        void'($urandom(71182));
        errCount   = 0;
        checksDone = 0;
        testCount  = 0;
        passCount  = 0;
        sclkRises  = 0;
        csnRises   = 0;
        repeat (4) @(negedge clk);   // Reset over 4 cycles
        reset <= 1'b0;
        @(negedge clk);

        startTest();
        checkBit("reset csn", 1'b1, spi.csn);
        checkBit("reset sclk", spiPkg::SPI_CPOL, spi.sclk);
        checkBit("reset mosi", 1'b0, spi.mosi);
        checkBit("reset txReady", 1'b1, txReady);
        checkBit("reset rxValid", 1'b0, rxValid);
        finishTest("reset");

        startTest();
        base = sclkRises;
        sendByte("single", spiPkg::spiByte_t'($urandom));
        waitRxValid("single", cycles, ok);
        if (ok) checkFrame("single");
        waitCsnHigh("single");
        checkInt("single sclk rises", spiPkg::SPI_WIDTH, sclkRises - base);
        finishTest("single");

        startTest();
        sendByte("latency", spiPkg::spiByte_t'($urandom));
        waitRxValid("latency", cycles, ok);   // Counts from the accepting edge
        checkInt("latency cycles", 1 + 17 * spiPkg::SCLK_HALF_DIV, cycles);
        if (ok) checkFrame("latency");
        waitCsnHigh("latency");
        finishTest("latency");

        startTest();
        b0 = spiPkg::spiByte_t'($urandom);
        b1 = spiPkg::spiByte_t'($urandom);
        sendByte("b2b first", b0);
        waitRxValid("b2b first", cycles, ok);
        if (ok) checkFrame("b2b first");
        base = csnRises;
        sendByte("b2b second", b1);   // Same falling edge as the pulse
        waitRxValid("b2b second", cycles, ok);
        if (ok) checkFrame("b2b second");
        checkInt("b2b csn rises", base, csnRises);
        waitCsnHigh("b2b");
        finishTest("backToBack");

        startTest();
        b0 = spiPkg::spiByte_t'($urandom);
        sendByte("ignore", b0);
        repeat (8) @(negedge clk);   // Well inside the frame
        checkBit("ignore txReady", 1'b0, txReady);
        txByte  = ~b0;
        txValid = 1'b1;
        @(negedge clk);
        txValid = 1'b0;
        waitRxValid("ignore", cycles, ok);
        if (ok) checkFrame("ignore");
        waitCsnHigh("ignore");
        repeat (4) @(negedge clk);
        checkBit("ignore csn after frame", 1'b1, spi.csn);
        checkInt("ignore extra frames", 0, mosiQ.size());
        finishTest("ignoredStrobe");

        startTest();
        b2b = 1'b0;
        for (int i = 0; i < 200; i++) begin
            if (!b2b) begin
                gap = $urandom_range(0, 7);
                repeat (gap) @(negedge clk);
            end
            sendByte("random", spiPkg::spiByte_t'($urandom));
            waitRxValid("random", cycles, ok);
            if (ok) checkFrame("random");
            b2b = ($urandom_range(0, 1) == 1);   // Next byte right on the pulse
        end
        waitCsnHigh("random");
        finishTest("random");

        errCount += dut0.chk0.failCount;   // Pin and strobe assertions
        $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
                 testCount, passCount, testCount - passCount, checksDone, errCount);
        if (errCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
spiPkg.sv
spiClockGen.sv
spiShifter.sv
spiController.sv
spiTop.sv
spiTb_chk.sv
spiTb.sv

/* run.sh */
#!/bin/sh
# Build and run the SPI master testbench with Verilator.
# Exits non-zero when the build, the run or the result check fails.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --assert -j 0 --top-module spiTb -Mdir obj_dir \
    -o spiTbSim -f vlog.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed"
    exit 1
fi

./obj_dir/spiTbSim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" "$SIM_LOG"; then
    echo "result: pass"
    exit 0
fi
echo "result: fail"
exit 1
